/* hw/id_config.svh */
`default_nettype none

`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// ======================================================================
// Datapath widths
// ======================================================================

`define ID_XLEN       32 // Data and address width
`define ID_REG_AW     5  // Register file address width

// ======================================================================
// Fixed encodings
// ======================================================================

`define ID_INSTR_STEP 4  // Link address increment, no compressed

`endif

`default_nettype wire

/* hw/id_pkg.sv */
`include "id_config.svh"
`default_nettype none

package id_pkg;

	// Major opcodes, anything else decodes as illegal
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'h03,
		OPC_OP_IMM = 7'h13,
		OPC_AUIPC  = 7'h17,
		OPC_STORE  = 7'h23,
		OPC_OP     = 7'h33,
		OPC_LUI    = 7'h37,
		OPC_BRANCH = 7'h63,
		OPC_JAL    = 7'h6f
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_e;

	typedef enum logic [1:0] {OP_A_REG_A, OP_A_PC, OP_A_ZERO} op_a_sel_e;

	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_INCR} imm_sel_e;

	typedef enum logic {ID_FIRST, ID_MULTI} id_state_e;

	typedef enum logic [1:0] {LSU_WORD, LSU_HALF, LSU_BYTE} lsu_type_e;

	typedef struct packed {
		alu_op_e   alu_op;
		op_a_sel_e op_a_sel;
		logic      op_b_is_imm;  // Else register B
		imm_sel_e  imm_sel;
		logic      rf_we;
		logic      rf_ren_a;
		logic      rf_ren_b;
		logic      lsu_req;
		logic      lsu_we;
		lsu_type_e lsu_type;
		logic      lsu_sign_ext;
		logic      branch;
		logic      jump;
		logic      illegal;
	} decode_t;

	typedef struct packed {
		alu_op_e              op;
		logic [`ID_XLEN-1:0] operand_a;
		logic [`ID_XLEN-1:0] operand_b;
	} alu_req_t;

	typedef struct packed {
		logic                req;
		logic                we;
		lsu_type_e           data_type;
		logic                sign_ext;
		logic [`ID_XLEN-1:0] wdata;
	} lsu_req_t;

endpackage

`default_nettype wire

/* hw/id_decoder.sv */
`include "id_config.svh"
`timescale 1ns/1ps
`default_nettype none

module id_decoder import id_pkg::*; (
	input  logic [`ID_XLEN-1:0]   instr_rdata_i,
	input  logic                  instr_first_cycle_i,
	output decode_t               decode_o,
	output logic [`ID_REG_AW-1:0] rf_raddr_a_o,
	output logic [`ID_REG_AW-1:0] rf_raddr_b_o,
	output logic [`ID_REG_AW-1:0] rf_waddr_o
);
	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	decode_t    dec;

	assign opcode = opcode_e'(instr_rdata_i[6:0]);
	assign funct3 = instr_rdata_i[14:12];
	assign funct7 = instr_rdata_i[31:25];

	always_comb begin
		dec          = '0;
		dec.alu_op   = ALU_ADD;
		dec.op_a_sel = OP_A_REG_A;
		dec.imm_sel  = IMM_I;
		dec.lsu_type = LSU_WORD;

		case (opcode)
			OPC_OP: begin
				dec.rf_we    = 1'b1;
				dec.rf_ren_a = 1'b1;
				dec.rf_ren_b = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'b000}: dec.alu_op = ALU_ADD;
					{7'h20, 3'b000}: dec.alu_op = ALU_SUB;
					{7'h00, 3'b001}: dec.alu_op = ALU_SLL;
					{7'h00, 3'b010}: dec.alu_op = ALU_SLT;
					{7'h00, 3'b011}: dec.alu_op = ALU_SLTU;
					{7'h00, 3'b100}: dec.alu_op = ALU_XOR;
					{7'h00, 3'b101}: dec.alu_op = ALU_SRL;
					{7'h20, 3'b101}: dec.alu_op = ALU_SRA;
					{7'h00, 3'b110}: dec.alu_op = ALU_OR;
					{7'h00, 3'b111}: dec.alu_op = ALU_AND;
					default:         dec.illegal = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				dec.rf_we       = 1'b1;
				dec.rf_ren_a    = 1'b1;
				dec.op_b_is_imm = 1'b1;
				case (funct3)
					3'b000: dec.alu_op = ALU_ADD;
					3'b010: dec.alu_op = ALU_SLT;
					3'b011: dec.alu_op = ALU_SLTU;
					3'b100: dec.alu_op = ALU_XOR;
					3'b110: dec.alu_op = ALU_OR;
					3'b111: dec.alu_op = ALU_AND;
					3'b001: begin
						dec.alu_op  = ALU_SLL;
						dec.illegal = (funct7 != 7'h00); // shamt[5] not allowed on RV32
					end
					default: begin
						if (funct7 == 7'h00)      dec.alu_op = ALU_SRL;
						else if (funct7 == 7'h20) dec.alu_op = ALU_SRA;
						else                      dec.illegal = 1'b1;
					end
				endcase
			end
			OPC_LUI, OPC_AUIPC: begin
				dec.rf_we       = 1'b1;
				dec.op_a_sel    = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
				dec.op_b_is_imm = 1'b1;
				dec.imm_sel     = IMM_U;
			end
			OPC_LOAD, OPC_STORE: begin
				dec.lsu_req      = 1'b1;
				dec.lsu_we       = (opcode == OPC_STORE);
				dec.rf_we        = (opcode == OPC_LOAD);
				dec.rf_ren_a     = 1'b1;
				dec.rf_ren_b     = (opcode == OPC_STORE);
				dec.op_b_is_imm  = 1'b1;
				dec.imm_sel      = (opcode == OPC_STORE) ? IMM_S : IMM_I;
				dec.lsu_sign_ext = ~funct3[2];
				case (funct3[1:0])
					2'b00:   dec.lsu_type = LSU_BYTE;
					2'b01:   dec.lsu_type = LSU_HALF;
					2'b10:   dec.lsu_type = LSU_WORD;
					default: dec.illegal  = 1'b1;
				endcase
				// Unsigned word and unsigned store do not exist
				if (funct3[2] && (opcode == OPC_STORE || funct3[1]))
					dec.illegal = 1'b1;
			end
			OPC_BRANCH: begin
				dec.branch = 1'b1;
				if (instr_first_cycle_i) begin
					dec.rf_ren_a = 1'b1; // Compare cycle
					dec.rf_ren_b = 1'b1;
				end else begin
					dec.op_a_sel    = OP_A_PC; // Target cycle
					dec.op_b_is_imm = 1'b1;
					dec.imm_sel     = IMM_B;
				end
				case (funct3)
					3'b000:  dec.alu_op = instr_first_cycle_i ? ALU_EQ  : ALU_ADD;
					3'b001:  dec.alu_op = instr_first_cycle_i ? ALU_NE  : ALU_ADD;
					3'b100:  dec.alu_op = instr_first_cycle_i ? ALU_LT  : ALU_ADD;
					3'b101:  dec.alu_op = instr_first_cycle_i ? ALU_GE  : ALU_ADD;
					3'b110:  dec.alu_op = instr_first_cycle_i ? ALU_LTU : ALU_ADD;
					3'b111:  dec.alu_op = instr_first_cycle_i ? ALU_GEU : ALU_ADD;
					default: dec.illegal = 1'b1;
				endcase
			end
			OPC_JAL: begin
				dec.jump        = 1'b1;
				dec.op_a_sel    = OP_A_PC;
				dec.op_b_is_imm = 1'b1;
				dec.imm_sel     = instr_first_cycle_i ? IMM_J : IMM_INCR;
				dec.rf_we       = ~instr_first_cycle_i; // Link in second cycle
			end
			default: dec.illegal = 1'b1;
		endcase

		if (dec.illegal) begin
			dec.rf_we    = 1'b0;
			dec.rf_ren_a = 1'b0;
			dec.rf_ren_b = 1'b0;
			dec.lsu_req  = 1'b0;
			dec.lsu_we   = 1'b0;
			dec.branch   = 1'b0;
			dec.jump     = 1'b0;
		end
	end

	assign decode_o = dec;

	// Idle read ports stay on x0
	assign rf_raddr_a_o = dec.rf_ren_a ? instr_rdata_i[19:15] : '0;
	assign rf_raddr_b_o = dec.rf_ren_b ? instr_rdata_i[24:20] : '0;
	assign rf_waddr_o   = instr_rdata_i[11:7];

endmodule

`default_nettype wire

/* hw/id_operand_mux.sv */
`include "id_config.svh"
`timescale 1ns/1ps
`default_nettype none

module id_operand_mux import id_pkg::*; (
	input  logic [`ID_XLEN-1:0] instr_rdata_i,
	input  logic [`ID_XLEN-1:0] pc_id_i,
	input  logic [`ID_XLEN-1:0] rf_rdata_a_i,
	input  logic [`ID_XLEN-1:0] rf_rdata_b_i,
	input  decode_t             decode_i,
	output alu_req_t            alu_o,
	output logic [`ID_XLEN-1:0] lsu_wdata_o
);
	logic [`ID_XLEN-1:0] imm_i;
	logic [`ID_XLEN-1:0] imm_s;
	logic [`ID_XLEN-1:0] imm_b;
	logic [`ID_XLEN-1:0] imm_u;
	logic [`ID_XLEN-1:0] imm_j;
	logic [`ID_XLEN-1:0] imm_sel;

	// ======================================================================
	// Immediates
	// ======================================================================

	assign imm_i = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
	assign imm_s = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
	assign imm_b = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
	                instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
	assign imm_u = {instr_rdata_i[31:12], 12'b0};
	assign imm_j = {{11{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[19:12],
	                instr_rdata_i[20], instr_rdata_i[30:21], 1'b0};

	always_comb begin
		case (decode_i.imm_sel)
			IMM_I:   imm_sel = imm_i;
			IMM_S:   imm_sel = imm_s;
			IMM_B:   imm_sel = imm_b;
			IMM_U:   imm_sel = imm_u;
			IMM_J:   imm_sel = imm_j;
			default: imm_sel = `ID_XLEN'(`ID_INSTR_STEP); // Link increment
		endcase
	end

	// ======================================================================
	// Operand selection
	// ======================================================================

	always_comb begin
		alu_o.op = decode_i.alu_op;
		case (decode_i.op_a_sel)
			OP_A_REG_A: alu_o.operand_a = rf_rdata_a_i;
			OP_A_PC:    alu_o.operand_a = pc_id_i;
			default:    alu_o.operand_a = '0;
		endcase
		alu_o.operand_b = decode_i.op_b_is_imm ? imm_sel : rf_rdata_b_i;
	end

	assign lsu_wdata_o = rf_rdata_b_i; // Store data, unaligned as read

endmodule

`default_nettype wire

/* hw/id_ctrl_fsm.sv */
`include "id_config.svh"
`timescale 1ns/1ps
`default_nettype none

module id_ctrl_fsm import id_pkg::*; (
	input  logic    clk_i,
	input  logic    rst_ni,
	input  logic    instr_valid_i,
	input  decode_t decode_i,
	input  logic    branch_decision_i,
	input  logic    lsu_resp_valid_i,
	output logic    instr_first_cycle_o,
	output logic    pc_set_o,
	output logic    instr_id_done_o,
	output logic    id_in_ready_o,
	output logic    rf_we_o,
	output logic    lsu_req_o
);
	id_state_e state_q;
	id_state_e state_d;
	logic      exec;
	logic      stall;
	logic      pc_set;

	assign exec                = instr_valid_i & ~decode_i.illegal;
	assign instr_first_cycle_o = instr_valid_i & (state_q == ID_FIRST);

	// ======================================================================
	// Issue FSM
	// ======================================================================

	always_comb begin
		state_d = state_q;
		stall   = 1'b0;
		pc_set  = 1'b0;
		if (exec) begin
			case (state_q)
				ID_FIRST: begin
					if (decode_i.lsu_req) begin
						state_d = ID_MULTI; // Response never in request cycle
						stall   = 1'b1;
					end else if (decode_i.branch) begin
						if (branch_decision_i) begin
							state_d = ID_MULTI;
							stall   = 1'b1;
						end
					end else if (decode_i.jump) begin
						state_d = ID_MULTI;
						stall   = 1'b1;
						pc_set  = 1'b1; // Jump target first
					end
				end
				default: begin
					if (decode_i.lsu_req && !lsu_resp_valid_i) begin
						stall = 1'b1; // Wait for memory
					end else begin
						state_d = ID_FIRST;
						pc_set  = decode_i.branch; // Taken branch target
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= ID_FIRST;
		end else begin
			state_q <= state_d;
		end
	end

	assign instr_id_done_o = instr_valid_i & ~stall;
	assign id_in_ready_o   = instr_id_done_o | ~instr_valid_i;
	assign pc_set_o        = pc_set;
	assign rf_we_o         = exec & decode_i.rf_we & ~stall; // Write on completion only
	assign lsu_req_o       = exec & decode_i.lsu_req & instr_first_cycle_o;

endmodule

`default_nettype wire

/* hw/id_stage.sv */
`include "id_config.svh"
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  instr_valid_i,
	input  logic [`ID_XLEN-1:0]   instr_rdata_i,
	input  logic [`ID_XLEN-1:0]   pc_id_i,
	input  logic                  branch_decision_i,
	input  logic                  lsu_resp_valid_i,
	input  logic [`ID_XLEN-1:0]   rf_rdata_a_i,
	input  logic [`ID_XLEN-1:0]   rf_rdata_b_i,
	output logic [`ID_REG_AW-1:0] rf_raddr_a_o,
	output logic [`ID_REG_AW-1:0] rf_raddr_b_o,
	output logic [`ID_REG_AW-1:0] rf_waddr_o,
	output logic                  rf_we_o,
	output alu_req_t              alu_o,
	output lsu_req_t              lsu_o,
	output logic                  illegal_insn_o,
	output logic                  id_in_ready_o,
	output logic                  instr_id_done_o,
	output logic                  pc_set_o
);
	decode_t             decode;
	logic                instr_first_cycle;
	logic                lsu_req;
	logic [`ID_XLEN-1:0] lsu_wdata;

	id_decoder id_decoder_i (
		.instr_rdata_i      (instr_rdata_i),
		.instr_first_cycle_i(instr_first_cycle),
		.decode_o           (decode),
		.rf_raddr_a_o       (rf_raddr_a_o),
		.rf_raddr_b_o       (rf_raddr_b_o),
		.rf_waddr_o         (rf_waddr_o)
	);

	id_operand_mux id_operand_mux_i (
		.instr_rdata_i(instr_rdata_i),
		.pc_id_i      (pc_id_i),
		.rf_rdata_a_i (rf_rdata_a_i),
		.rf_rdata_b_i (rf_rdata_b_i),
		.decode_i     (decode),
		.alu_o        (alu_o),
		.lsu_wdata_o  (lsu_wdata)
	);

	id_ctrl_fsm id_ctrl_fsm_i (
		.clk_i              (clk_i),
		.rst_ni             (rst_ni),
		.instr_valid_i      (instr_valid_i),
		.decode_i           (decode),
		.branch_decision_i  (branch_decision_i),
		.lsu_resp_valid_i   (lsu_resp_valid_i),
		.instr_first_cycle_o(instr_first_cycle),
		.pc_set_o           (pc_set_o),
		.instr_id_done_o    (instr_id_done_o),
		.id_in_ready_o      (id_in_ready_o),
		.rf_we_o            (rf_we_o),
		.lsu_req_o          (lsu_req)
	);

	assign lsu_o = '{
		req:       lsu_req,
		we:        decode.lsu_we,
		data_type: decode.lsu_type,
		sign_ext:  decode.lsu_sign_ext,
		wdata:     lsu_wdata
	};

	assign illegal_insn_o = instr_valid_i & decode.illegal;

endmodule

`default_nettype wire

/* sim/id_tb_clk.sv */
`timescale 1ns/1ps
`default_nettype none

module id_tb_clk (
	output logic clk_o,
	output logic rst_no
);
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o; // 10 ns period
	end

	initial begin
		rst_no = 1'b0;
		repeat (4) @(posedge clk_o);
		rst_no <= 1'b1;
	end

endmodule

`default_nettype wire

/* sim/id_stage_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_chk (
	input logic clk_i,
	input logic rst_ni,
	input logic valid_i,
	input logic done_i,
	input logic pc_set_i,
	input logic lsu_req_i
);
	int unsigned fail_cnt;

	initial fail_cnt = 0;

	assert property (@(posedge clk_i) disable iff (!rst_ni) !(pc_set_i && lsu_req_i))
	else begin
		fail_cnt++;
		$error("pc_set_o high together with a load/store request");
	end

	// Request only in the first cycle
	assert property (@(posedge clk_i) disable iff (!rst_ni) lsu_req_i |=> !lsu_req_i)
	else begin
		fail_cnt++;
		$error("lsu request held past the first cycle");
	end

	assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |-> valid_i)
	else begin
		fail_cnt++;
		$error("instr_id_done_o high without a valid instruction");
	end

	assert property (@(posedge clk_i) !rst_ni |-> !pc_set_i && !done_i)
	else begin
		fail_cnt++;
		$error("pc_set_o or instr_id_done_o high during reset");
	end

endmodule

bind id_stage id_stage_chk id_stage_chk_i (
	.clk_i    (clk_i),
	.rst_ni   (rst_ni),
	.valid_i  (instr_valid_i),
	.done_i   (instr_id_done_o),
	.pc_set_i (pc_set_o),
	.lsu_req_i(lsu_o.req)
);

`default_nettype wire

/* sim/id_stage_tb.sv */
`include "id_config.svh"
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb import id_pkg::*; ();
	localparam int NUM_TESTS = 6;
	localparam int PER_TEST  = 40;
	localparam int MAX_DLY   = 5;
	localparam int WDOG_NS   = (NUM_TESTS * PER_TEST * (MAX_DLY + 3) + 20) * 10;

	typedef struct packed {
		alu_req_t alu;
		lsu_req_t lsu;
		logic     rf_we;
		logic     pc_set;
		logic     done;
		logic     illegal;
		logic     ren_a;
		logic     ren_b;
	} expect_t;

	localparam alu_op_e BASE_OP [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
	                                    ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
	localparam alu_op_e BR_OP [8]   = '{ALU_EQ, ALU_NE, ALU_ADD, ALU_ADD,
	                                    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};

	logic                  clk_i;
	logic                  rst_ni;
	logic                  instr_valid_i;
	logic                  branch_decision_i;
	logic                  lsu_resp_valid_i;
	logic [`ID_XLEN-1:0]   instr_rdata_i;
	logic [`ID_XLEN-1:0]   pc_id_i;
	logic [`ID_XLEN-1:0]   rf_rdata_a_i;
	logic [`ID_XLEN-1:0]   rf_rdata_b_i;
	logic [`ID_REG_AW-1:0] rf_raddr_a_o;
	logic [`ID_REG_AW-1:0] rf_raddr_b_o;
	logic [`ID_REG_AW-1:0] rf_waddr_o;
	logic                  rf_we_o;
	alu_req_t              alu_o;
	lsu_req_t              lsu_o;
	logic                  illegal_insn_o;
	logic                  id_in_ready_o;
	logic                  instr_id_done_o;
	logic                  pc_set_o;

	int          cur_cyc;   // Cycle index within the current instruction
	logic        done_seen;
	int          errors = 0;
	int          checks = 0;
	expect_t     exp_q;
	string       test_names [NUM_TESTS] = '{"OP and OP-IMM", "LUI and AUIPC",
	                                       "load and store", "branch", "JAL", "illegal"};

	id_tb_clk id_tb_clk_i (.clk_o(clk_i), .rst_no(rst_ni));

	id_stage id_stage_i (.*);

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic expect_t ref_model(input logic [31:0] ins, input logic [31:0] pc,
	                                      input logic [31:0] a, input logic [31:0] b,
	                                      input int cyc, input logic taken, input logic resp);
		expect_t     e;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		f3    = ins[14:12];
		f7    = ins[31:25];
		imm_i = $signed(ins) >>> 20;
		imm_s = {imm_i[31:5], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'h000};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		e               = '0;
		e.alu.op        = ALU_ADD;
		e.lsu.data_type = LSU_WORD;
		e.lsu.wdata     = b; // Store data always shows register B
		e.done          = 1'b1;
		case (ins[6:0])
			7'h33: begin
				e.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				e.alu     = '{f7[5] ? (f3 == 3'd0 ? ALU_SUB : ALU_SRA) : BASE_OP[f3], a, b};
				e.rf_we   = 1'b1;
				e.ren_a   = 1'b1;
				e.ren_b   = 1'b1;
			end
			7'h13: begin
				e.illegal = (f3 == 3'd1 && f7 != 7'h00) ||
				            (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
				e.alu     = '{(f3 == 3'd5 && f7[5]) ? ALU_SRA : BASE_OP[f3], a, imm_i};
				e.rf_we   = 1'b1;
				e.ren_a   = 1'b1;
			end
			7'h37, 7'h17: begin
				e.alu   = '{ALU_ADD, ins[5] ? 32'h0 : pc, imm_u}; // LUI has bit 5 set
				e.rf_we = 1'b1;
			end
			7'h03, 7'h23: begin
				e.alu           = '{ALU_ADD, a, ins[5] ? imm_s : imm_i};
				e.illegal       = (f3[1:0] == 2'b11) || (f3[2] && (ins[5] || f3[1]));
				e.lsu.req       = (cyc == 0);
				e.lsu.we        = ins[5];
				e.lsu.data_type = f3[1] ? LSU_WORD : (f3[0] ? LSU_HALF : LSU_BYTE);
				e.lsu.sign_ext  = !f3[2];
				e.done          = (cyc > 0) && resp;
				e.rf_we         = e.done && !ins[5];
				e.ren_a         = 1'b1;
				e.ren_b         = ins[5];
			end
			7'h63: begin
				e.illegal = (f3[2:1] == 2'b01);
				e.alu     = (cyc == 0) ? alu_req_t'{BR_OP[f3], a, b} :
				                         alu_req_t'{ALU_ADD, pc, imm_b};
				e.pc_set  = (cyc != 0);
				e.done    = (cyc != 0) || !taken;
				e.ren_a   = (cyc == 0);
				e.ren_b   = (cyc == 0);
			end
			7'h6f: begin
				e.alu    = '{ALU_ADD, pc, (cyc == 0) ? imm_j : 32'(`ID_INSTR_STEP)};
				e.pc_set = (cyc == 0);
				e.done   = (cyc != 0);
				e.rf_we  = (cyc != 0);
			end
			default: e.illegal = 1'b1;
		endcase
		if (e.illegal) begin
			e.rf_we   = 1'b0;
			e.pc_set  = 1'b0;
			e.lsu.req = 1'b0;
			e.lsu.we  = 1'b0;
			e.done    = 1'b1;
			e.ren_a   = 1'b0;
			e.ren_b   = 1'b0;
		end
		return e;
	endfunction

	function automatic logic [31:0] make_instr(input int t);
		logic [31:0] r;
		r = $urandom;
		case (t)
			1: begin
				if (r[0])
					r[31:25] = {1'b0, r[30] & ~r[13] & (r[14] == r[12]), 5'h0}; // SUB, SRA
				else if (r[13:12] == 2'b01)
					r[31:25] = {1'b0, r[30] & r[14], 5'h0}; // Immediate shifts
				r[6:0] = r[0] ? 7'h33 : 7'h13;
			end
			2: r[6:0] = r[0] ? 7'h37 : 7'h17;
			3: begin
				if (r[13:12] == 2'b11)
					r[12] = 1'b0;
				if (r[13] || r[0])
					r[14] = 1'b0; // Word and store are signed only
				r[6:0] = r[0] ? 7'h23 : 7'h03;
			end
			4: begin
				if (r[14:13] == 2'b01)
					r[13] = 1'b0;
				r[6:0] = 7'h63;
			end
			5: r[6:0] = 7'h6f;
			default: begin
				if (r[0])
					r[1] = 1'b0; // Compressed quadrants
				else
					{r[31:25], r[6:0]} = {7'h01, 7'h33}; // M extension
			end
		endcase
		return r;
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic check_alu(input alu_req_t got, input alu_req_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Error alu_o: got %h expected %h", got, want);
		end
	endtask

	task automatic check_lsu(input lsu_req_t got, input lsu_req_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Error lsu_o: got %h expected %h", got, want);
		end
	endtask

	task automatic check_addr(input string name, input logic [`ID_REG_AW-1:0] got,
	                          input logic [`ID_REG_AW-1:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Error %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Error %s: got %h expected %h", name, got, want);
		end
	endtask

	always @(negedge clk_i) begin
		if (rst_ni && instr_valid_i) begin
			exp_q = ref_model(instr_rdata_i, pc_id_i, rf_rdata_a_i, rf_rdata_b_i, cur_cyc,
			                  branch_decision_i, lsu_resp_valid_i);
			if (!exp_q.illegal)
				check_alu(alu_o, exp_q.alu);
			check_lsu(lsu_o, exp_q.lsu);
			check_bit("rf_we_o", rf_we_o, exp_q.rf_we);
			check_bit("pc_set_o", pc_set_o, exp_q.pc_set);
			check_bit("instr_id_done_o", instr_id_done_o, exp_q.done);
			check_bit("id_in_ready_o", id_in_ready_o, exp_q.done);
			check_bit("illegal_insn_o", illegal_insn_o, exp_q.illegal);
			if (exp_q.rf_we)
				check_addr("rf_waddr_o", rf_waddr_o, instr_rdata_i[11:7]);
			if (exp_q.ren_a)
				check_addr("rf_raddr_a_o", rf_raddr_a_o, instr_rdata_i[19:15]);
			if (exp_q.ren_b)
				check_addr("rf_raddr_b_o", rf_raddr_b_o, instr_rdata_i[24:20]);
			done_seen = instr_id_done_o;
		end
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial begin
		int cyc;
		int dly;
		int err_start;
		void'($urandom(32'h823e));
		done_seen         = 1'b0;
		instr_valid_i     <= 1'b0;
		instr_rdata_i     <= '0;
		pc_id_i           <= '0;
		branch_decision_i <= 1'b0;
		lsu_resp_valid_i  <= 1'b0;
		rf_rdata_a_i      <= '0;
		rf_rdata_b_i      <= '0;
		cur_cyc           <= 0;
		@(posedge rst_ni);
		@(posedge clk_i);
		for (int t = 1; t <= NUM_TESTS; t++) begin
			err_start = errors;
			for (int n = 0; n < PER_TEST; n++) begin
				cyc = 0;
				dly = $urandom_range(MAX_DLY);
				instr_valid_i     <= 1'b1;
				instr_rdata_i     <= make_instr(t);
				pc_id_i           <= $urandom & 32'hffff_fffc;
				rf_rdata_a_i      <= $urandom;
				rf_rdata_b_i      <= $urandom;
				branch_decision_i <= 1'($urandom);
				do begin
					lsu_resp_valid_i <= (cyc == dly + 1); // Response never in request cycle
					cur_cyc          <= cyc;
					cyc++;
					@(posedge clk_i);
				end while (!done_seen);
			end
			$display("Test %0d (%s): %0d errors", t, test_names[t-1], errors - err_start);
		end
		instr_valid_i    <= 1'b0;
		lsu_resp_valid_i <= 1'b0;
		@(posedge clk_i);
		errors += id_stage_i.id_stage_chk_i.fail_cnt;
		$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
		         id_stage_i.id_stage_chk_i.fail_cnt);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#WDOG_NS;
		$display("Timeout: the instruction sequence did not complete in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_operand_mux.sv
hw/id_ctrl_fsm.sv
hw/id_stage.sv
sim/id_tb_clk.sv
sim/id_stage_chk.sv
sim/id_stage_tb.sv

/* Bender.yml */
package:
  name: id_stage

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/id_pkg.sv
      - hw/id_decoder.sv
      - hw/id_operand_mux.sv
      - hw/id_ctrl_fsm.sv
      - hw/id_stage.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/id_tb_clk.sv
      - sim/id_stage_chk.sv
      - sim/id_stage_tb.sv
